//--- hdl/switch_pkg.sv
package switch_pkg;

    // one bus word
    typedef logic [15:0] word_t;

    typedef logic [3:0] port_id_t;
    typedef logic [2:0] prior_t;

    // payload words after the header, 0 for a header-only packet
    typedef logic [8:0] pkt_len_t;

    // same bit layout as the header word on the bus
    typedef struct packed {
        port_id_t dest;
        prior_t   prior;
        pkt_len_t length;
    } pkt_hdr_t;

    // at or above this the packet goes to the high queue
    localparam prior_t HIGH_PRIOR = 3'd4;

endpackage

//--- hdl/buffer_pkg.sv
package buffer_pkg;

    localparam int PAGE_WORDS = 8;
    localparam int NUM_PAGES = 64;

    typedef logic [5:0] page_ptr_t;
    typedef logic [2:0] slot_t;

    // page number in the top bits, slot below
    typedef logic [8:0] sram_addr_t;

    // xor of both bytes of every word in the page
    typedef logic [7:0] ecc_code_t;

    typedef logic [6:0] free_cnt_t;

    // room for a 257-word packet
    localparam int FULL_PAGES = 33;
    localparam int AFULL_PAGES = 40;

    localparam int QUEUE_DEPTH = 16;

    typedef struct packed {
        page_ptr_t           head;
        switch_pkg::pkt_hdr_t hdr;
    } pkt_desc_t;

endpackage

//--- hdl/port_frontend.sv
`timescale 1ns/1ps

module port_frontend (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_sop,
    input  logic                 wr_eop,
    input  logic                 wr_vld,
    input  switch_pkg::word_t    wr_data,
    output logic                 hdr_vld,
    output switch_pkg::pkt_hdr_t hdr,
    output logic                 data_vld,
    output switch_pkg::word_t    data
);
    import switch_pkg::*;

    logic in_pkt;
    word_t data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
            hdr_vld <= 1'b0;
            data_vld <= 1'b0;
        end else begin
            hdr_vld <= wr_vld && wr_sop;
            // stray vld outside a packet is dropped
            data_vld <= wr_vld && !wr_sop && in_pkt;
            if (wr_vld && wr_eop) begin
                in_pkt <= 1'b0;
            end else if (wr_vld && wr_sop) begin
                in_pkt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= wr_data;
    end

    assign data = data_q;
    assign hdr = pkt_hdr_t'(data_q);

endmodule

//--- hdl/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  switch_pkg::pkt_len_t len,
    input  logic                 step,
    output buffer_pkg::slot_t    slot,
    output logic                 page_end,
    output logic                 last
);
    import switch_pkg::*;
    import buffer_pkg::*;

    pkt_len_t remain;

    always_ff @(posedge clk) begin
        if (reset) begin
            remain <= '0;
            slot <= '0;
        end else if (load) begin
            remain <= len;
            slot <= '0;
        end else if (step) begin
            remain <= remain - 1'b1;
            slot <= slot + 1'b1;
        end
    end

    assign page_end = (slot == slot_t'(PAGE_WORDS - 1));
    assign last = (remain == pkt_len_t'(1));

endmodule

//--- hdl/page_manager.sv
`timescale 1ns/1ps

module page_manager (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,
    output buffer_pkg::page_ptr_t free_head,
    input  logic                  release_en,
    input  buffer_pkg::page_ptr_t release_page,
    input  logic                  link_en,
    input  buffer_pkg::page_ptr_t link_from,
    input  buffer_pkg::page_ptr_t link_to,
    input  buffer_pkg::page_ptr_t next_addr,
    output buffer_pkg::page_ptr_t next_page,
    output buffer_pkg::free_cnt_t free_count
);
    import buffer_pkg::*;

    page_ptr_t free_list [NUM_PAGES];
    page_ptr_t jump_table [NUM_PAGES];
    page_ptr_t head_ptr;
    page_ptr_t tail_ptr;

    // circular free list holding every page after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PAGES; i++) begin
                free_list[i] <= page_ptr_t'(i);
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            free_count <= free_cnt_t'(NUM_PAGES);
        end else begin
            if (alloc) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (release_en) begin
                free_list[tail_ptr] <= release_page;
                tail_ptr <= tail_ptr + 1'b1;
            end
            case ({alloc, release_en})
                2'b10: free_count <= free_count - 1'b1;
                2'b01: free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase
        end
    end

    assign free_head = free_list[head_ptr];

    always_ff @(posedge clk) begin
        if (link_en) begin
            jump_table[link_from] <= link_to;
        end
    end

    assign next_page = jump_table[next_addr];

endmodule

//--- hdl/packet_sram.sv
`timescale 1ns/1ps

module packet_sram (
    input  logic                   clk,
    input  logic                   wr_en,
    input  buffer_pkg::sram_addr_t wr_addr,
    input  switch_pkg::word_t      din,
    input  logic                   rd_en,
    input  buffer_pkg::sram_addr_t rd_addr,
    output switch_pkg::word_t      dout,
    input  logic                   code_wr_en,
    input  buffer_pkg::page_ptr_t  code_page,
    input  buffer_pkg::ecc_code_t  code_din,
    input  buffer_pkg::page_ptr_t  code_rd_page,
    output buffer_pkg::ecc_code_t  code_dout
);
    import switch_pkg::*;
    import buffer_pkg::*;

    word_t data_mem [NUM_PAGES * PAGE_WORDS];
    ecc_code_t code_mem [NUM_PAGES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr] <= din;
        end
        if (rd_en) begin
            dout <= data_mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (code_wr_en) begin
            code_mem[code_page] <= code_din;
        end
        code_dout <= code_mem[code_rd_page];
    end

endmodule

//--- hdl/write_ctrl.sv
`timescale 1ns/1ps

module write_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hdr_vld,
    input  switch_pkg::pkt_hdr_t   hdr,
    input  logic                   data_vld,
    input  switch_pkg::word_t      data,
    output logic                   alloc,
    input  buffer_pkg::page_ptr_t  free_head,
    output logic                   link_en,
    output buffer_pkg::page_ptr_t  link_from,
    output buffer_pkg::page_ptr_t  link_to,
    output logic                   wr_en,
    output buffer_pkg::sram_addr_t wr_addr,
    output switch_pkg::word_t      din,
    output logic                   code_wr_en,
    output buffer_pkg::page_ptr_t  code_page,
    output buffer_pkg::ecc_code_t  code_din,
    output logic                   desc_push,
    output buffer_pkg::pkt_desc_t  desc
);
    import switch_pkg::*;
    import buffer_pkg::*;

    typedef enum logic [1:0] {IDLE, FILL, CLOSE} state_t;

    state_t state;
    page_ptr_t cur_page;
    pkt_desc_t cur_desc;
    ecc_code_t code_acc;
    ecc_code_t code_next;
    slot_t slot;
    logic page_end;
    logic last;
    logic start;
    logic store;

    // a header may follow straight after the previous close
    assign start = hdr_vld && (state != FILL);
    assign store = data_vld && (state == FILL);

    beat_counter wr_counter (
        .clk(clk),
        .reset(reset),
        .load(start),
        .len(hdr.length),
        .step(store),
        .slot(slot),
        .page_end(page_end),
        .last(last)
    );

    assign code_next = ((slot == '0) ? '0 : code_acc) ^ data[15:8] ^ data[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (start) begin
            state <= (hdr.length == '0) ? CLOSE : FILL;
        end else if (store && last) begin
            state <= CLOSE;
        end else if (state == CLOSE) begin
            state <= IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_page <= free_head;
            cur_desc <= '{head: free_head, hdr: hdr};
            code_acc <= '0;
        end else if (store) begin
            code_acc <= code_next;
            if (page_end && !last) begin
                cur_page <= free_head;
            end
        end
    end

    // next page taken and chained when a page fills mid-packet
    assign alloc = start || link_en;
    assign link_en = store && page_end && !last;
    assign link_from = cur_page;
    assign link_to = free_head;

    assign wr_en = store;
    assign wr_addr = {cur_page, slot};
    assign din = data;

    assign code_wr_en = link_en || (state == CLOSE);
    assign code_page = cur_page;
    assign code_din = (state == CLOSE) ? code_acc : code_next;

    assign desc_push = (state == CLOSE);
    assign desc = cur_desc;

endmodule

//--- hdl/read_ctrl.sv
`timescale 1ns/1ps

module read_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   desc_push,
    input  buffer_pkg::pkt_desc_t  desc,
    output logic                   q_full,
    input  logic                   ready,
    output logic                   rd_en,
    output buffer_pkg::sram_addr_t rd_addr,
    output buffer_pkg::page_ptr_t  code_rd_page,
    input  switch_pkg::word_t      dout,
    input  buffer_pkg::ecc_code_t  code_dout,
    output buffer_pkg::page_ptr_t  next_addr,
    input  buffer_pkg::page_ptr_t  next_page,
    output logic                   release_en,
    output buffer_pkg::page_ptr_t  release_page,
    output logic                   rd_sop,
    output logic                   rd_eop,
    output logic                   rd_vld,
    output switch_pkg::word_t      rd_data,
    output logic                   ecc_err
);
    import switch_pkg::*;
    import buffer_pkg::*;

    localparam int QW = $clog2(QUEUE_DEPTH);

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD} state_t;

    // queue 1 is high priority, queue 0 low
    pkt_desc_t queue [2][QUEUE_DEPTH];
    logic [QW-1:0] wr_ptr [2];
    logic [QW-1:0] rd_ptr [2];
    logic [QW:0] count [2];

    state_t state;
    pkt_desc_t cur;
    page_ptr_t cur_page;
    slot_t slot;
    logic page_end;
    logic last;
    logic push_sel;
    logic pop;
    logic pop_sel;
    logic hdr_issue;
    logic issue;
    logic out_hdr;
    logic out_first;
    logic out_chk;
    word_t hdr_word;
    ecc_code_t code_acc;
    ecc_code_t code_now;

    assign push_sel = (desc.hdr.prior >= HIGH_PRIOR);
    assign pop_sel = (count[1] != '0);
    assign pop = (state == IDLE) && ((count[1] != '0) || (count[0] != '0));
    assign q_full = (count[0] == QUEUE_DEPTH) || (count[1] == QUEUE_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int q = 0; q < 2; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q] <= '0;
            end
        end else begin
            for (int q = 0; q < 2; q++) begin
                if (desc_push && (push_sel == q[0])) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop && (pop_sel == q[0])) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                count[q] <= count[q] + (desc_push && (push_sel == q[0]))
                                     - (pop && (pop_sel == q[0]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_push) begin
            queue[push_sel][wr_ptr[push_sel]] <= desc;
        end
    end

    assign hdr_issue = (state == HEADER) && ready;
    assign issue = (state == PAYLOAD) && ready;

    beat_counter rd_counter (
        .clk(clk),
        .reset(reset),
        .load(hdr_issue),
        .len(cur.hdr.length),
        .step(issue),
        .slot(slot),
        .page_end(page_end),
        .last(last)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (pop) state <= HEADER;
                HEADER: if (ready) state <= (cur.hdr.length == '0) ? IDLE : PAYLOAD;
                PAYLOAD: if (ready && last) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= queue[pop_sel][rd_ptr[pop_sel]];
            cur_page <= queue[pop_sel][rd_ptr[pop_sel]].head;
        end else if (issue && page_end && !last) begin
            cur_page <= next_page;
        end
        if (hdr_issue) begin
            hdr_word <= word_t'(cur.hdr);
        end
    end

    assign rd_en = issue;
    assign rd_addr = {cur_page, slot};
    assign code_rd_page = cur_page;
    assign next_addr = cur_page;

    // page goes back once its last beat is issued
    assign release_en = (hdr_issue && (cur.hdr.length == '0)) || (issue && (page_end || last));
    assign release_page = cur_page;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_vld <= 1'b0;
            rd_sop <= 1'b0;
            rd_eop <= 1'b0;
            out_hdr <= 1'b0;
            out_chk <= 1'b0;
            out_first <= 1'b0;
            ecc_err <= 1'b0;
        end else begin
            rd_vld <= hdr_issue || issue;
            rd_sop <= hdr_issue;
            rd_eop <= (hdr_issue && (cur.hdr.length == '0)) || (issue && last);
            out_hdr <= hdr_issue;
            out_chk <= issue && (page_end || last);
            out_first <= issue && (slot == '0);
            ecc_err <= rd_vld && out_chk && (code_now != code_dout);
        end
    end

    // fold returning payload words, restarting at each page
    assign code_now = (out_first ? '0 : code_acc) ^ dout[15:8] ^ dout[7:0];

    always_ff @(posedge clk) begin
        if (rd_vld && !out_hdr) begin
            code_acc <= code_now;
        end
    end

    assign rd_data = out_hdr ? hdr_word : dout;

endmodule

//--- hdl/packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_sop,
    input  logic              wr_eop,
    input  logic              wr_vld,
    input  switch_pkg::word_t wr_data,
    input  logic              ready,
    output logic              full,
    output logic              almost_full,
    output logic              rd_sop,
    output logic              rd_eop,
    output logic              rd_vld,
    output switch_pkg::word_t rd_data,
    output logic              ecc_err
);
    import switch_pkg::*;
    import buffer_pkg::*;

    logic hdr_vld;
    pkt_hdr_t hdr;
    logic data_vld;
    word_t data;
    logic alloc;
    page_ptr_t free_head;
    logic release_en;
    page_ptr_t release_page;
    logic link_en;
    page_ptr_t link_from;
    page_ptr_t link_to;
    page_ptr_t next_addr;
    page_ptr_t next_page;
    free_cnt_t free_count;
    logic wr_en;
    sram_addr_t wr_addr;
    word_t din;
    logic rd_en;
    sram_addr_t rd_addr;
    word_t dout;
    logic code_wr_en;
    page_ptr_t code_page;
    ecc_code_t code_din;
    page_ptr_t code_rd_page;
    ecc_code_t code_dout;
    logic desc_push;
    pkt_desc_t desc;
    logic q_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full <= (free_count < FULL_PAGES) || q_full;
            almost_full <= (free_count < AFULL_PAGES) || q_full;
        end
    end

    port_frontend frontend_inst (
        .clk(clk), .reset(reset),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .hdr_vld(hdr_vld), .hdr(hdr), .data_vld(data_vld), .data(data)
    );

    write_ctrl write_inst (
        .clk(clk), .reset(reset),
        .hdr_vld(hdr_vld), .hdr(hdr), .data_vld(data_vld), .data(data),
        .alloc(alloc), .free_head(free_head),
        .link_en(link_en), .link_from(link_from), .link_to(link_to),
        .wr_en(wr_en), .wr_addr(wr_addr), .din(din),
        .code_wr_en(code_wr_en), .code_page(code_page), .code_din(code_din),
        .desc_push(desc_push), .desc(desc)
    );

    page_manager page_inst (
        .clk(clk), .reset(reset),
        .alloc(alloc), .free_head(free_head),
        .release_en(release_en), .release_page(release_page),
        .link_en(link_en), .link_from(link_from), .link_to(link_to),
        .next_addr(next_addr), .next_page(next_page), .free_count(free_count)
    );

    packet_sram sram_inst (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .din(din),
        .rd_en(rd_en), .rd_addr(rd_addr), .dout(dout),
        .code_wr_en(code_wr_en), .code_page(code_page), .code_din(code_din),
        .code_rd_page(code_rd_page), .code_dout(code_dout)
    );

    read_ctrl read_inst (
        .clk(clk), .reset(reset),
        .desc_push(desc_push), .desc(desc), .q_full(q_full), .ready(ready),
        .rd_en(rd_en), .rd_addr(rd_addr), .code_rd_page(code_rd_page),
        .dout(dout), .code_dout(code_dout),
        .next_addr(next_addr), .next_page(next_page),
        .release_en(release_en), .release_page(release_page),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data),
        .ecc_err(ecc_err)
    );

endmodule

//--- verif/packet_buffer_assertions.sv
`timescale 1ns/1ps

module packet_buffer_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  ready,
    input logic                  rd_sop,
    input logic                  rd_eop,
    input logic                  rd_vld,
    input logic                  ecc_err,
    input logic                  alloc,
    input buffer_pkg::free_cnt_t free_count
);

    // output packet started and not yet ended
    logic out_open;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_open <= 1'b0;
        end else if (rd_vld && rd_eop) begin
            out_open <= 1'b0;
        end else if (rd_vld && rd_sop) begin
            out_open <= 1'b1;
        end
    end

    vld_after_ready: assert property (@(posedge clk) disable iff (reset)
        rd_vld |-> $past(ready, 1) || $past(ready, 2))
        else $error("rd_vld without ready in the two cycles before");

    sop_with_vld: assert property (@(posedge clk) disable iff (reset)
        rd_sop |-> rd_vld)
        else $error("rd_sop without rd_vld");

    eop_with_vld: assert property (@(posedge clk) disable iff (reset)
        rd_eop |-> rd_vld)
        else $error("rd_eop without rd_vld");

    sop_between_packets: assert property (@(posedge clk) disable iff (reset)
        rd_vld && rd_sop |-> !out_open)
        else $error("rd_sop before the previous packet ended");

    beat_inside_packet: assert property (@(posedge clk) disable iff (reset)
        rd_vld && !rd_sop |-> out_open)
        else $error("payload beat outside a packet");

    no_code_error: assert property (@(posedge clk) disable iff (reset)
        !ecc_err)
        else $error("page code mismatch on the read side");

    alloc_with_room: assert property (@(posedge clk) disable iff (reset)
        alloc |-> free_count != '0)
        else $error("page taken from an empty free list");

endmodule

//--- verif/packet_buffer_tb.sv
`timescale 1ns/1ps

module packet_buffer_tb;
    import switch_pkg::*;
    import buffer_pkg::*;

    localparam logic [31:0] SEED = 32'h7496_81ff;
    // worst-case beats of each test, in run order
    localparam int TOTAL_BEATS = 287 + 96 + 696 + 287 + 12800 + 257;
    localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 4 + 2000;

    localparam int DATA_ERR = 0;
    localparam int FRAME_ERR = 1;
    localparam int ORDER_ERR = 2;
    localparam int FLAG_ERR = 3;

    logic clk;
    logic reset;
    logic wr_sop;
    logic wr_eop;
    logic wr_vld;
    word_t wr_data;
    logic ready;
    logic full;
    logic almost_full;
    logic rd_sop;
    logic rd_eop;
    logic rd_vld;
    word_t rd_data;
    logic ecc_err;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    int ready_mode;
    logic strict_order;
    word_t exp_hi [$];
    word_t exp_lo [$];
    logic cur_cls;
    int beats_left;
    int beats_seen;
    int words_sent;
    int err_count [4];
    int lens [6] = '{0, 1, 7, 8, 9, 256};

    packet_buffer packet_buffer_inst (
        .clk(clk), .reset(reset),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .ready(ready), .full(full), .almost_full(almost_full),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data),
        .ecc_err(ecc_err)
    );

    bind packet_buffer packet_buffer_assertions assertions_inst (
        .clk(clk), .reset(reset), .ready(ready),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .ecc_err(ecc_err),
        .alloc(alloc), .free_count(free_count)
    );

    always #50 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[14:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_failure(input int kind, input string msg);
        err_count[kind]++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic push_expected(input logic cls, input word_t w);
        words_sent++;
        if (cls) begin
            exp_hi.push_back(w);
        end else begin
            exp_lo.push_back(w);
        end
    endtask

    function automatic logic pop_expected(input logic cls, output word_t w);
        w = '0;
        if (cls && exp_hi.size() != 0) begin
            w = exp_hi.pop_front();
            return 1'b1;
        end
        if (!cls && exp_lo.size() != 0) begin
            w = exp_lo.pop_front();
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic send_packet(input prior_t prior, input int len);
        pkt_hdr_t hdr;
        word_t word;
        logic cls;
        hdr.dest = port_id_t'(take_bits(4));
        hdr.prior = prior;
        hdr.length = pkt_len_t'(len);
        cls = (prior >= HIGH_PRIOR);
        while (full) begin
            @(negedge clk);
        end
        push_expected(cls, word_t'(hdr));
        wr_vld = 1'b1;
        wr_sop = 1'b1;
        wr_eop = (len == 0);
        wr_data = word_t'(hdr);
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            word = take_bits(16);
            push_expected(cls, word);
            wr_sop = 1'b0;
            wr_eop = (i == len - 1);
            wr_data = word;
        end
        @(negedge clk);
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        // descriptor push and flag register settle
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_drained();
        while (exp_hi.size() != 0 || exp_lo.size() != 0 || beats_left != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic check_flags(input int free_pages);
        if (almost_full !== (free_pages < AFULL_PAGES)) begin
            report_failure(FLAG_ERR, $sformatf("almost_full %b with %0d free pages",
                                               almost_full, free_pages));
        end
        if (full !== (free_pages < FULL_PAGES)) begin
            report_failure(FLAG_ERR, $sformatf("full %b with %0d free pages",
                                               full, free_pages));
        end
    endtask

    always @(negedge clk) begin
        if (ready_mode == 2) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            ready = ready_lfsr[0];
        end else begin
            ready = (ready_mode == 1);
        end
    end

    // scoreboard
    always @(negedge clk) begin
        word_t exp_word;
        pkt_hdr_t hdr_seen;
        logic have;
        if (!reset && rd_vld) begin
            beats_seen++;
            hdr_seen = rd_data;
            if (rd_sop) begin
                if (beats_left != 0) begin
                    report_failure(FRAME_ERR, "sop before the previous packet ended");
                end
                cur_cls = (hdr_seen.prior >= HIGH_PRIOR);
                if (strict_order && !cur_cls && exp_hi.size() != 0) begin
                    report_failure(ORDER_ERR, "low packet ahead of a waiting high packet");
                end
            end else if (beats_left == 0) begin
                report_failure(FRAME_ERR, "beat outside a packet");
            end
            have = pop_expected(cur_cls, exp_word);
            if (!have) begin
                report_failure(DATA_ERR, $sformatf("unexpected beat %h", rd_data));
            end else if (rd_data !== exp_word) begin
                report_failure(DATA_ERR, $sformatf("data %h, expected %h", rd_data, exp_word));
            end
            if (rd_sop) begin
                hdr_seen = have ? exp_word : rd_data;
                beats_left = int'(hdr_seen.length);
            end else if (beats_left > 0) begin
                beats_left--;
            end
            if (rd_eop !== (beats_left == 0)) begin
                report_failure(FRAME_ERR, $sformatf("eop %b, %0d beats left", rd_eop, beats_left));
            end
        end else if (!reset && ready_mode == 1 && beats_left != 0) begin
            report_failure(FRAME_ERR, "gap inside a packet with ready held high");
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, %0d beats received", TIMEOUT_CYCLES, beats_seen);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [15:0] bits;
        int len;
        clk = 1'b0;
        reset = 1'b1;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        wr_vld = 1'b0;
        wr_data = '0;
        ready = 1'b0;
        stim_lfsr = SEED;
        ready_lfsr = SEED;
        ready_mode = 0;
        strict_order = 1'b0;
        cur_cls = 1'b0;
        beats_left = 0;
        beats_seen = 0;
        words_sent = 0;
        for (int k = 0; k < 4; k++) begin
            err_count[k] = 0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // single packets at the page edges
        ready_mode = 1;
        for (int i = 0; i < 6; i++) begin
            bits = take_bits(3);
            send_packet(prior_t'(bits[2:0]), lens[i]);
        end
        wait_drained();

        // first packet is high as it is popped before ready rises
        ready_mode = 0;
        repeat (2) @(negedge clk);
        for (int i = 0; i < 6; i++) begin
            bits = take_bits(2);
            len = int'(take_bits(4));
            send_packet({~i[0], bits[1:0]}, len);
        end
        strict_order = 1'b1;
        ready_mode = 1;
        wait_drained();
        strict_order = 1'b0;

        // long packets under random back-pressure
        ready_mode = 2;
        for (int i = 0; i < 3; i++) begin
            bits = take_bits(3);
            len = 200 + int'(take_bits(5));
            send_packet(prior_t'(bits[2:0]), len);
        end
        wait_drained();

        // 40 payload words fill five pages since the header lives in the descriptor
        ready_mode = 0;
        repeat (2) @(negedge clk);
        for (int i = 1; i <= 7; i++) begin
            bits = take_bits(3);
            send_packet(prior_t'(bits[2:0]), 40);
            check_flags(NUM_PAGES - 5 * i);
        end
        ready_mode = 1;
        wait_drained();
        check_flags(NUM_PAGES);

        ready_mode = 2;
        for (int i = 0; i < 200; i++) begin
            bits = take_bits(3);
            len = int'(take_bits(6));
            send_packet(prior_t'(bits[2:0]), len);
        end
        wait_drained();
        check_flags(NUM_PAGES);

        // 256 payload words take 32 pages
        ready_mode = 1;
        bits = take_bits(3);
        send_packet(prior_t'(bits[2:0]), 256);
        wait_drained();

        if (beats_seen != words_sent) begin
            report_failure(FRAME_ERR, $sformatf("%0d beats received for %0d words sent",
                                                beats_seen, words_sent));
        end
        $display("error counts: data %0d, framing %0d, order %0d, flags %0d, beats %0d",
                 err_count[DATA_ERR], err_count[FRAME_ERR], err_count[ORDER_ERR],
                 err_count[FLAG_ERR], beats_seen);
        if (err_count[0] + err_count[1] + err_count[2] + err_count[3] == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/switch_pkg.sv
hdl/buffer_pkg.sv
hdl/port_frontend.sv
hdl/beat_counter.sv
hdl/page_manager.sv
hdl/packet_sram.sv
hdl/write_ctrl.sv
hdl/read_ctrl.sv
hdl/packet_buffer.sv
verif/packet_buffer_assertions.sv
verif/packet_buffer_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= packet_buffer_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -j 0
PASS_MSG ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
